/* verilog/cssStylePkg.sv */
package cssStylePkg;

	localparam int colorW = 32; // argb word
	localparam int identW = 10; // value identifier

	// primitive unit types, same codes as the css engine uses
	typedef enum logic [6:0] {
		unitUnknown = 7'd0,
		unitNumber = 7'd1,
		unitPercentage = 7'd2,
		unitEms = 7'd3,
		unitPx = 7'd5,
		unitString = 7'd19,
		unitUri = 7'd20,
		unitIdent = 7'd21,
		unitRgbColor = 7'd25
	} unitType_e;

	typedef enum logic [identW-1:0] {
		cssValueInvalid = 10'd0,
		cssValueAqua = 10'd1,               cssValueBlack = 10'd2,
		cssValueBlue = 10'd3,               cssValueFuchsia = 10'd4,
		cssValueGray = 10'd5,               cssValueGreen = 10'd6,
		cssValueLime = 10'd7,               cssValueMaroon = 10'd8,
		cssValueNavy = 10'd9,               cssValueOlive = 10'd10,
		cssValueOrange = 10'd11,            cssValuePurple = 10'd12,
		cssValueRed = 10'd13,               cssValueSilver = 10'd14,
		cssValueTeal = 10'd15,              cssValueWhite = 10'd16,
		cssValueYellow = 10'd17,            cssValueTransparent = 10'd18,
		cssValueGrey = 10'd19,
		// system colors
		cssValueActiveborder = 10'd20,      cssValueActivecaption = 10'd21,
		cssValueAppworkspace = 10'd22,      cssValueBackground = 10'd23,
		cssValueButtonface = 10'd24,        cssValueButtonhighlight = 10'd25,
		cssValueButtonshadow = 10'd26,      cssValueButtontext = 10'd27,
		cssValueCaptiontext = 10'd28,       cssValueGraytext = 10'd29,
		cssValueHighlight = 10'd30,         cssValueHighlighttext = 10'd31,
		cssValueInactiveborder = 10'd32,    cssValueInactivecaption = 10'd33,
		cssValueInactivecaptiontext = 10'd34, cssValueInfobackground = 10'd35,
		cssValueInfotext = 10'd36,
		// context colors, resolved against the document
		cssValueWebkitText = 10'd37,        cssValueWebkitLink = 10'd38,
		cssValueWebkitActivelink = 10'd39,  cssValueWebkitFocusRingColor = 10'd40,
		cssValueCurrentcolor = 10'd41
	} cssValue_e;

	typedef enum logic [4:0] {
		displayInline = 5'd0,
		displayBlock = 5'd1,
		displayListItem = 5'd2,
		displayInlineBlock = 5'd3,
		displayTable = 5'd4,
		displayInlineTable = 5'd5,
		displayFlex = 5'd6,
		displayInlineFlex = 5'd7,
		displayGrid = 5'd8,
		displayNone = 5'd9
	} displayValue_e;

	typedef enum logic [5:0] {
		noPseudo = 6'd0,
		pseudoFirstLine = 6'd1,
		pseudoFirstLetter = 6'd2,
		pseudoBefore = 6'd3,
		pseudoAfter = 6'd4,
		pseudoSelection = 6'd5
	} styleType_e;

	localparam logic [colorW-1:0] colorTransparent = 32'h0000_0000;
	localparam logic [colorW-1:0] colorAqua = 32'hFF00_FFFF;
	localparam logic [colorW-1:0] colorBlack = 32'hFF00_0000;
	localparam logic [colorW-1:0] colorBlue = 32'hFF00_00FF;
	localparam logic [colorW-1:0] colorFuchsia = 32'hFFFF_00FF;
	localparam logic [colorW-1:0] colorGray = 32'hFF80_8080; // grey too
	localparam logic [colorW-1:0] colorGreen = 32'hFF00_8000;
	localparam logic [colorW-1:0] colorLime = 32'hFF00_FF00;
	localparam logic [colorW-1:0] colorMaroon = 32'hFF80_0000;
	localparam logic [colorW-1:0] colorNavy = 32'hFF00_0080;
	localparam logic [colorW-1:0] colorOlive = 32'hFF80_8000;
	localparam logic [colorW-1:0] colorOrange = 32'hFFFF_A500;
	localparam logic [colorW-1:0] colorPurple = 32'hFF80_0080;
	localparam logic [colorW-1:0] colorRed = 32'hFFFF_0000;
	localparam logic [colorW-1:0] colorSilver = 32'hFFC0_C0C0;
	localparam logic [colorW-1:0] colorTeal = 32'hFF00_8080;
	localparam logic [colorW-1:0] colorWhite = 32'hFFFF_FFFF;
	localparam logic [colorW-1:0] colorYellow = 32'hFFFF_FF00;

endpackage

/* verilog/valueDecode.sv */
`timescale 1ns/1ps

module valueDecode (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input cssStylePkg::unitType_e unitType,
	input logic [cssStylePkg::identW-1:0] valueIdent,
	input logic [cssStylePkg::colorW-1:0] rgbValue,
	input logic forVisitedLink,
	input logic isLinkElement,
	input logic [cssStylePkg::colorW-1:0] inheritedColor,
	input logic elementValid,
	input logic isSvgElement,
	input cssStylePkg::styleType_e styleType,
	input cssStylePkg::displayValue_e display,
	output logic s1Valid,
	output logic s1IsRgb,
	output logic [cssStylePkg::identW-1:0] s1Ident,
	output logic [cssStylePkg::colorW-1:0] s1Rgb,
	output logic s1UseVisited,
	output logic [cssStylePkg::colorW-1:0] s1Inherited,
	output logic s1DisplayValid
);
	import cssStylePkg::*;

	logic isIdent;
	logic displayKindOk;
	logic displayOk;

	assign isIdent = (unitType == unitIdent);
	assign displayKindOk = (display == displayInline) || (display == displayBlock)
		|| (display == displayNone);
	// svg element without pseudo style and a simple display kind
	assign displayOk = elementValid && isSvgElement && (styleType == noPseudo)
		&& displayKindOk;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			s1Valid <= 1'b0;
			s1IsRgb <= 1'b0;
			s1Ident <= '0;
			s1Rgb <= '0;
			s1UseVisited <= 1'b0;
			s1Inherited <= '0;
			s1DisplayValid <= 1'b0;
		end
		else
		begin
			s1Valid <= inValid;
			if (inValid)
			begin
				s1IsRgb <= (unitType == unitRgbColor);
				s1Ident <= isIdent ? valueIdent : '0; // non-ident units look up nothing
				s1Rgb <= rgbValue;
				s1UseVisited <= forVisitedLink & isLinkElement; // visited only on a link
				s1Inherited <= inheritedColor;
				s1DisplayValid <= displayOk;
			end
		end
	end

	// an accepted item must carry a known unit type into the pipe
	unitTypeKnown: assert property (@(posedge clk) disable iff (!rstN)
		inValid |-> !$isunknown(unitType))
		else $error("unit type has unknown bits on an accepted item");

endmodule

/* verilog/namedColorTable.sv */
`timescale 1ns/1ps

module namedColorTable (
	input logic clk,
	input logic rstN,
	input logic s1Valid,
	input logic s1IsRgb,
	input logic [cssStylePkg::identW-1:0] s1Ident,
	input logic [cssStylePkg::colorW-1:0] s1Rgb,
	input logic s1UseVisited,
	input logic [cssStylePkg::colorW-1:0] s1Inherited,
	input logic s1DisplayValid,
	output logic s2Valid,
	output logic s2IsRgb,
	output logic [cssStylePkg::identW-1:0] s2Ident,
	output logic [cssStylePkg::colorW-1:0] s2Rgb,
	output logic s2UseVisited,
	output logic [cssStylePkg::colorW-1:0] s2Inherited,
	output logic [cssStylePkg::colorW-1:0] s2TableColor,
	output logic s2DisplayValid
);
	import cssStylePkg::*;

	logic [colorW-1:0] tableColor;

	always_comb
	begin
		case (cssValue_e'(s1Ident))
			cssValueAqua: tableColor = colorAqua;
			cssValueBlack: tableColor = colorBlack;
			cssValueBlue: tableColor = colorBlue;
			cssValueFuchsia: tableColor = colorFuchsia;
			cssValueGray: tableColor = colorGray;
			cssValueGrey: tableColor = colorGray; // alternate spelling
			cssValueGreen: tableColor = colorGreen;
			cssValueLime: tableColor = colorLime;
			cssValueMaroon: tableColor = colorMaroon;
			cssValueNavy: tableColor = colorNavy;
			cssValueOlive: tableColor = colorOlive;
			cssValueOrange: tableColor = colorOrange;
			cssValuePurple: tableColor = colorPurple;
			cssValueRed: tableColor = colorRed;
			cssValueSilver: tableColor = colorSilver;
			cssValueTeal: tableColor = colorTeal;
			cssValueWhite: tableColor = colorWhite;
			cssValueYellow: tableColor = colorYellow;
			cssValueTransparent: tableColor = colorTransparent;
			// default theme system colors
			cssValueActiveborder: tableColor = 32'hFFFF_FFFF;
			cssValueActivecaption: tableColor = 32'hFFCC_CCCC;
			cssValueAppworkspace: tableColor = 32'hFFFF_FFFF;
			cssValueBackground: tableColor = 32'hFF63_63CE;
			cssValueButtonface: tableColor = 32'hFFC0_C0C0;
			cssValueButtonhighlight: tableColor = 32'hFFDD_DDDD;
			cssValueButtonshadow: tableColor = 32'hFF88_8888;
			cssValueButtontext: tableColor = 32'hFF00_0000;
			cssValueCaptiontext: tableColor = 32'hFF00_0000;
			cssValueGraytext: tableColor = 32'hFF80_8080;
			cssValueHighlight: tableColor = 32'hFFB5_D5FF;
			cssValueHighlighttext: tableColor = 32'hFF00_0000;
			cssValueInactiveborder: tableColor = 32'hFFFF_FFFF;
			cssValueInactivecaption: tableColor = 32'hFFFF_FFFF;
			cssValueInactivecaptiontext: tableColor = 32'hFF7F_7F7F;
			cssValueInfobackground: tableColor = 32'hFFFB_FCC5;
			cssValueInfotext: tableColor = 32'hFF00_0000;
			default: tableColor = colorTransparent; // zero, context or unmapped ident
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			s2Valid <= 1'b0;
			s2IsRgb <= 1'b0;
			s2Ident <= '0;
			s2Rgb <= '0;
			s2UseVisited <= 1'b0;
			s2Inherited <= '0;
			s2TableColor <= '0;
			s2DisplayValid <= 1'b0;
		end
		else
		begin
			s2Valid <= s1Valid;
			if (s1Valid)
			begin
				s2IsRgb <= s1IsRgb;
				s2Ident <= s1Ident; // context idents are picked in stage 3
				s2Rgb <= s1Rgb;
				s2UseVisited <= s1UseVisited;
				s2Inherited <= s1Inherited;
				s2TableColor <= tableColor;
				s2DisplayValid <= s1DisplayValid;
			end
		end
	end

endmodule

/* verilog/contextColorSelect.sv */
`timescale 1ns/1ps

module contextColorSelect #(
	parameter logic [cssStylePkg::colorW-1:0] focusRingColor = cssStylePkg::colorWhite
) (
	input logic clk,
	input logic rstN,
	input logic s2Valid,
	input logic s2IsRgb,
	input logic [cssStylePkg::identW-1:0] s2Ident,
	input logic [cssStylePkg::colorW-1:0] s2Rgb,
	input logic s2UseVisited,
	input logic [cssStylePkg::colorW-1:0] s2Inherited,
	input logic [cssStylePkg::colorW-1:0] s2TableColor,
	input logic s2DisplayValid,
	input logic [cssStylePkg::colorW-1:0] textColor,
	input logic [cssStylePkg::colorW-1:0] linkColor,
	input logic [cssStylePkg::colorW-1:0] visitedLinkColor,
	input logic [cssStylePkg::colorW-1:0] activeLinkColor,
	output logic outValid,
	output logic [cssStylePkg::colorW-1:0] color,
	output logic displayValid
);
	import cssStylePkg::*;

	logic [colorW-1:0] docLinkColor;
	logic [colorW-1:0] nextColor;

	assign docLinkColor = s2UseVisited ? visitedLinkColor : linkColor;

	// rgb word wins, then document context, then the table
	always_comb
	begin
		if (s2IsRgb)
		begin
			nextColor = s2Rgb;
		end
		else
		begin
			case (cssValue_e'(s2Ident))
				cssValueWebkitText: nextColor = textColor;
				cssValueWebkitLink: nextColor = docLinkColor;
				cssValueWebkitActivelink: nextColor = activeLinkColor;
				cssValueWebkitFocusRingColor: nextColor = focusRingColor;
				cssValueCurrentcolor: nextColor = s2Inherited; // parent's color
				default: nextColor = s2TableColor;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			color <= '0;
			displayValid <= 1'b0;
		end
		else
		begin
			outValid <= s2Valid;
			if (s2Valid)
			begin
				color <= nextColor;
				displayValid <= s2DisplayValid;
			end
		end
	end

	// the pipe is empty when reset lifts, so nothing may come out right after
	noOutAfterReset: assert property (@(posedge clk) $rose(rstN) |=> !outValid)
		else $error("output strobe right after reset release");

endmodule

/* verilog/styleResolvePipe.sv */
`timescale 1ns/1ps

module styleResolvePipe #(
	parameter logic [cssStylePkg::colorW-1:0] focusRingColor = cssStylePkg::colorWhite
) (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input cssStylePkg::unitType_e unitType,
	input logic [cssStylePkg::identW-1:0] valueIdent,
	input logic [cssStylePkg::colorW-1:0] rgbValue,
	input logic forVisitedLink,
	input logic isLinkElement,
	input logic [cssStylePkg::colorW-1:0] inheritedColor,
	input logic elementValid,
	input logic isSvgElement,
	input cssStylePkg::styleType_e styleType,
	input cssStylePkg::displayValue_e display,
	input logic [cssStylePkg::colorW-1:0] textColor,
	input logic [cssStylePkg::colorW-1:0] linkColor,
	input logic [cssStylePkg::colorW-1:0] visitedLinkColor,
	input logic [cssStylePkg::colorW-1:0] activeLinkColor,
	output logic outValid,
	output logic [cssStylePkg::colorW-1:0] color,
	output logic displayValid
);
	import cssStylePkg::*;

	logic s1Valid, s1IsRgb, s1UseVisited, s1DisplayValid;
	logic [identW-1:0] s1Ident;
	logic [colorW-1:0] s1Rgb, s1Inherited;

	logic s2Valid, s2IsRgb, s2UseVisited, s2DisplayValid;
	logic [identW-1:0] s2Ident;
	logic [colorW-1:0] s2Rgb, s2Inherited, s2TableColor;

	valueDecode uDecode (
		.clk(clk), .rstN(rstN), .inValid(inValid),
		.unitType(unitType), .valueIdent(valueIdent), .rgbValue(rgbValue),
		.forVisitedLink(forVisitedLink), .isLinkElement(isLinkElement),
		.inheritedColor(inheritedColor), .elementValid(elementValid),
		.isSvgElement(isSvgElement), .styleType(styleType), .display(display),
		.s1Valid(s1Valid), .s1IsRgb(s1IsRgb), .s1Ident(s1Ident), .s1Rgb(s1Rgb),
		.s1UseVisited(s1UseVisited), .s1Inherited(s1Inherited),
		.s1DisplayValid(s1DisplayValid)
	);

	namedColorTable uTable (
		.clk(clk), .rstN(rstN),
		.s1Valid(s1Valid), .s1IsRgb(s1IsRgb), .s1Ident(s1Ident), .s1Rgb(s1Rgb),
		.s1UseVisited(s1UseVisited), .s1Inherited(s1Inherited),
		.s1DisplayValid(s1DisplayValid),
		.s2Valid(s2Valid), .s2IsRgb(s2IsRgb), .s2Ident(s2Ident), .s2Rgb(s2Rgb),
		.s2UseVisited(s2UseVisited), .s2Inherited(s2Inherited),
		.s2TableColor(s2TableColor), .s2DisplayValid(s2DisplayValid)
	);

	contextColorSelect #(.focusRingColor(focusRingColor)) uSelect (
		.clk(clk), .rstN(rstN),
		.s2Valid(s2Valid), .s2IsRgb(s2IsRgb), .s2Ident(s2Ident), .s2Rgb(s2Rgb),
		.s2UseVisited(s2UseVisited), .s2Inherited(s2Inherited),
		.s2TableColor(s2TableColor), .s2DisplayValid(s2DisplayValid),
		.textColor(textColor), .linkColor(linkColor),
		.visitedLinkColor(visitedLinkColor), .activeLinkColor(activeLinkColor),
		.outValid(outValid), .color(color), .displayValid(displayValid)
	);

endmodule

/* verif/styleResolveTb.sv */
`timescale 1ns/1ps

module styleResolveTb;
	import cssStylePkg::*;

	localparam string inputFile = "verif/styleResolveInput.txt";
	localparam int latency = 3; // decode, table, select

	logic clk;
	logic rstN;
	logic inValid;
	unitType_e unitType;
	logic [identW-1:0] valueIdent;
	logic [colorW-1:0] rgbValue;
	logic forVisitedLink;
	logic isLinkElement;
	logic [colorW-1:0] inheritedColor;
	logic elementValid;
	logic isSvgElement;
	styleType_e styleType;
	displayValue_e display;
	logic [colorW-1:0] textColor;
	logic [colorW-1:0] linkColor;
	logic [colorW-1:0] visitedLinkColor;
	logic [colorW-1:0] activeLinkColor;
	logic outValid;
	logic [colorW-1:0] color;
	logic displayValid;

	string testLines[$];
	string nameQ[$]; // items in flight, oldest first
	logic [colorW-1:0] colorQ[$];
	logic displayQ[$];
	int dueQ[$]; // cycle at which each item must come out
	int cycleCount = 0;
	int cycleLimit = 0; // zero until the file is read
	bit failed = 1'b0;

	styleResolvePipe dut (
		.clk(clk), .rstN(rstN), .inValid(inValid),
		.unitType(unitType), .valueIdent(valueIdent), .rgbValue(rgbValue),
		.forVisitedLink(forVisitedLink), .isLinkElement(isLinkElement),
		.inheritedColor(inheritedColor), .elementValid(elementValid),
		.isSvgElement(isSvgElement), .styleType(styleType), .display(display),
		.textColor(textColor), .linkColor(linkColor),
		.visitedLinkColor(visitedLinkColor), .activeLinkColor(activeLinkColor),
		.outValid(outValid), .color(color), .displayValid(displayValid)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic abortRun();
		$display("Done: errors found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic reportProblem(input string reason);
		failed = 1'b1;
		$display("error: %s", reason);
		abortRun();
	endtask

	task automatic checkValue(input string testName, input string field,
		input logic [colorW-1:0] expected, input logic [colorW-1:0] actual);
		if (actual !== expected)
		begin
			failed = 1'b1;
			$display("mismatch in %s, %s: expected %h, actual %h", testName, field,
				expected, actual);
			abortRun();
		end
	endtask

	// keeps every non-empty line that is not a comment
	task automatic loadTests();
		int fd;
		string line;
		fd = $fopen(inputFile, "r");
		if (fd == 0)
			reportProblem({"cannot open the stimulus file ", inputFile});
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#")
				testLines.push_back(line);
		end
		$fclose(fd);
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
			reportProblem($sformatf("timeout, the run went past %0d cycles", cycleLimit));
	end

	// outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (outValid)
		begin
			if (nameQ.size() == 0)
				reportProblem("outValid went high with no item expected");
			checkValue(nameQ[0], "latency cycle", dueQ[0], cycleCount);
			checkValue(nameQ[0], "color", colorQ[0], color);
			checkValue(nameQ[0], "displayValid", displayQ[0], displayValid);
			void'(nameQ.pop_front());
			void'(colorQ.pop_front());
			void'(displayQ.pop_front());
			void'(dueQ.pop_front());
		end
		else if (dueQ.size() != 0 && cycleCount >= dueQ[0])
			reportProblem({"expected item ", nameQ[0], " never came out"});
	end

	initial
	begin
		string testName;
		logic [6:0] unitVal;
		logic [identW-1:0] identVal;
		logic [colorW-1:0] rgbVal;
		logic [colorW-1:0] inheritVal;
		logic [colorW-1:0] textVal;
		logic [colorW-1:0] linkCol;
		logic [colorW-1:0] visitedCol;
		logic [colorW-1:0] activeCol;
		logic [colorW-1:0] expColor;
		logic visitedFlag;
		logic linkFlag;
		logic elemVal;
		logic svgVal;
		logic expDisplay;
		logic [5:0] styleVal;
		logic [4:0] dispVal;
		int fields;
		int gap;

		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		unitType = unitUnknown;
		valueIdent = '0;
		rgbValue = '0;
		forVisitedLink = 1'b0;
		isLinkElement = 1'b0;
		inheritedColor = '0;
		elementValid = 1'b0;
		isSvgElement = 1'b0;
		styleType = noPseudo;
		display = displayInline;
		textColor = '0;
		linkColor = '0;
		visitedLinkColor = '0;
		activeLinkColor = '0;
		void'($urandom(32'h46eb_8619));

		loadTests();
		cycleLimit = 10 * testLines.size() + 50;

		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		repeat (3) @(posedge clk); // idle, the monitor flags any stray outValid
		#1;

		foreach (testLines[i])
		begin
			fields = $sscanf(testLines[i],
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				testName, unitVal, identVal, rgbVal, visitedFlag, linkFlag, inheritVal,
				elemVal, svgVal, styleVal, dispVal, textVal, linkCol, visitedCol,
				activeCol, expColor, expDisplay);
			if (fields != 17)
				reportProblem($sformatf("stimulus line %0d has %0d fields instead of 17",
					i + 1, fields));

			// document colors only change with the pipe empty
			if ({textVal, linkCol, visitedCol, activeCol} !==
				{textColor, linkColor, visitedLinkColor, activeLinkColor})
			begin
				inValid = 1'b0;
				while (dueQ.size() != 0)
				begin
					@(posedge clk);
					#1;
				end
				textColor = textVal;
				linkColor = linkCol;
				visitedLinkColor = visitedCol;
				activeLinkColor = activeCol;
			end

			gap = (i % 2 == 1) ? 0 : $urandom % 3; // odd items go back to back
			repeat (gap)
			begin
				inValid = 1'b0;
				@(posedge clk);
				#1;
			end

			inValid = 1'b1;
			unitType = unitType_e'(unitVal);
			valueIdent = identVal;
			rgbValue = rgbVal;
			forVisitedLink = visitedFlag;
			isLinkElement = linkFlag;
			inheritedColor = inheritVal;
			elementValid = elemVal;
			isSvgElement = svgVal;
			styleType = styleType_e'(styleVal);
			display = displayValue_e'(dispVal);
			nameQ.push_back(testName);
			colorQ.push_back(expColor);
			displayQ.push_back(expDisplay);
			dueQ.push_back(cycleCount + latency);
			@(posedge clk);
			#1;
		end

		inValid = 1'b0;
		while (dueQ.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk); // nothing may follow the last item

		if (!failed)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			abortRun();
	end

endmodule

/* verif/styleResolveInput.txt */
# name unit ident rgb visited isLink inherited elemValid svg style display (all hex after name)
# then textColor linkColor visitedLinkColor activeLinkColor expectedColor expectedDisplay
aqua       15 001 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF00FFFF 1
black      15 002 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF000000 1
blue       15 003 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF0000FF 1
fuchsia    15 004 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFF00FF 1
gray       15 005 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF808080 1
green      15 006 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF008000 1
lime       15 007 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF00FF00 1
maroon     15 008 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF800000 1
navy       15 009 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF000080 1
olive      15 00A 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF808000 1
orange     15 00B 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFFA500 1
purple     15 00C 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF800080 1
red        15 00D 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFF0000 1
silver     15 00E 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFC0C0C0 1
teal       15 00F 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF008080 1
white      15 010 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFFFFFF 1
yellow     15 011 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFFFF00 1
transp     15 012 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 00000000 1
grey       15 013 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF808080 1
actborder  15 014 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFFFFFF 1
background 15 017 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF6363CE 1
btnshadow  15 01A 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF888888 1
highlight  15 01E 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFB5D5FF 1
inactcapt  15 022 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF7F7F7F 1
infobg     15 023 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFBFCC5 1
infotext   15 024 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF000000 1
identZero  15 000 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 00000000 1
unmapped   15 02A 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 00000000 1
unmapHigh  15 3FF 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 00000000 1
pxUnit     05 010 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 00000000 1
numUnit    01 025 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 00000000 1
rgbPlain   19 000 80123456 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 80123456 1
rgbIdent   19 025 12345678 1 1 FF445566 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 12345678 1
ctxText    15 025 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF101010 1
ctxActive  15 027 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFF0000 1
ctxFocus   15 028 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFFFFFF 1
curColor   15 029 00000000 0 0 FF445566 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF445566 1
linkNone   15 026 00000000 0 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF0000EE 1
linkVisit  15 026 00000000 1 0 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF0000EE 1
linkElem   15 026 00000000 0 1 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF0000EE 1
linkBoth   15 026 00000000 1 1 00000000 1 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FF551A8B 1
ctxText2   15 025 00000000 0 0 00000000 1 1 00 00 FF202020 FF1111AA FF662299 FFEE0000 FF202020 1
linkBoth2  15 026 00000000 1 1 00000000 1 1 00 00 FF202020 FF1111AA FF662299 FFEE0000 FF662299 1
ctxActive2 15 027 00000000 0 0 00000000 1 1 00 00 FF202020 FF1111AA FF662299 FFEE0000 FFEE0000 1
dispBlock  19 000 FF0A0B0C 0 0 00000000 1 1 00 01 FF101010 FF0000EE FF551A8B FFFF0000 FF0A0B0C 1
dispNone   19 000 FF0D0E0F 0 0 00000000 1 1 00 09 FF101010 FF0000EE FF551A8B FFFF0000 FF0D0E0F 1
dispTable  19 000 FF111111 0 0 00000000 1 1 00 04 FF101010 FF0000EE FF551A8B FFFF0000 FF111111 0
dispFlex   19 000 FF222222 0 0 00000000 1 1 00 06 FF101010 FF0000EE FF551A8B FFFF0000 FF222222 0
dispList   19 000 FF333333 0 0 00000000 1 1 00 02 FF101010 FF0000EE FF551A8B FFFF0000 FF333333 0
notValid   15 00D 00000000 0 0 00000000 0 1 00 00 FF101010 FF0000EE FF551A8B FFFF0000 FFFF0000 0
notSvg     15 00D 00000000 0 0 00000000 1 0 00 01 FF101010 FF0000EE FF551A8B FFFF0000 FFFF0000 0
pseudoBef  15 003 00000000 0 0 00000000 1 1 03 00 FF101010 FF0000EE FF551A8B FFFF0000 FF0000FF 0
pseudoSel  15 003 00000000 0 0 00000000 1 1 05 09 FF101010 FF0000EE FF551A8B FFFF0000 FF0000FF 0

/* flist.f */
verilog/cssStylePkg.sv
verilog/valueDecode.sv
verilog/namedColorTable.sv
verilog/contextColorSelect.sv
verilog/styleResolvePipe.sv
verif/styleResolveTb.sv

/* Bender.yml */
package:
  name: style_resolve_pipe

sources:
  - verilog/cssStylePkg.sv
  - verilog/valueDecode.sv
  - verilog/namedColorTable.sv
  - verilog/contextColorSelect.sv
  - verilog/styleResolvePipe.sv
  - target: simulation
    files:
      - verif/styleResolveTb.sv
